// ==== qspi_mem.f ====
logic/qspi_mem_pkg.sv
logic/byte_ram.sv
logic/qspi_phy.sv
logic/qspi_mem_ctrl.sv
logic/qspi_mem_top.sv
dv/qspi_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the QSPI memory testbench with Verilator and run it.
# The result is taken from sim.log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=qspi_mem_sim
log_file=sim.log

verilator --binary --assert -Wno-fatal \
    --top-module qspi_mem_tb \
    -f qspi_mem.f \
    -Mdir "$build_dir" \
    -o "$sim_exe"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Checks failed" "$log_file"; then
    echo "simulation FAILED"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation PASSED"
exit 0

// ==== dv/qspi_mem_tb.sv ====
module qspi_mem_tb import qspi_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_depth = 256;
    localparam int half_qspi = 8;         // clk cycles per half qspi period.
    localparam int qspi_period_ns = 64;
    localparam int max_txns = 80 + mem_depth;    // final sweep adds at most one read per byte.
    localparam int timeout_ns = max_txns * 40 * qspi_period_ns * 2;

    logic    clk;
    logic    qspi_reset;
    logic    qspi_clk;
    logic    qspi_ncs;
    nibble_t io_in;
    nibble_t io_out;
    logic    io_oe;

    logic [31:0] lfsr_state;
    data_byte_t  model_mem [mem_depth];
    logic        model_valid [mem_depth];
    bus_addr_t   burst_addr [$];    // completed write bursts, reused by reads.
    int          burst_len [$];
    int          txn_count;

    qspi_mem_top #(
        .mem_depth (mem_depth)
    ) dut_i (
        .clk        (clk),
        .qspi_reset (qspi_reset),
        .qspi_clk   (qspi_clk),
        .qspi_ncs   (qspi_ncs),
        .io_in      (io_in),
        .io_out     (io_out),
        .io_oe      (io_oe)
    );

    initial clk = 1'b0;
    always #2 clk = !clk;

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_oe(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns io_oe: got %b, expected %b", $time, got, exp);
            $display("Checks failed");
            $fatal(1, "io_oe mismatch");
        end
    endtask

    task automatic check_byte(input data_byte_t got, input data_byte_t exp, input bus_addr_t addr);
        if (got !== exp) begin
            $display("[FAIL] %0t ns io_out byte at 0x%06h: got 0x%02h, expected 0x%02h",
                     $time, addr, got, exp);
            $display("Checks failed");
            $fatal(1, "read data mismatch");
        end
    endtask

    // falling edge with new data, sample just before the rising edge.
    task automatic qspi_cycle(input nibble_t d, input logic exp_oe, output nibble_t q);
        qspi_clk = 1'b0;
        io_in    = d;
        wait_clks(half_qspi);
        q = io_out;
        check_oe(io_oe, exp_oe);
        qspi_clk = 1'b1;
        wait_clks(half_qspi);
    endtask

    task automatic send_byte(input data_byte_t b);
        nibble_t unused_q;
        qspi_cycle(b[7:4], 1'b0, unused_q);    // high nibble first.
        qspi_cycle(b[3:0], 1'b0, unused_q);
    endtask

    task automatic begin_txn();
        qspi_ncs = 1'b0;
        txn_count++;
        wait_clks(half_qspi);
    endtask

    task automatic end_txn();
        qspi_ncs = 1'b1;
        wait_clks(half_qspi);
        check_oe(io_oe, 1'b0);
        wait_clks(half_qspi);
    endtask

    task automatic send_header(input logic is_read, input bus_addr_t addr);
        data_byte_t cmd;
        cmd = data_byte_t'(rand_bits(8));
        cmd[0] = !is_read;    // upper bits stay random.
        send_byte(cmd);
        send_byte(addr[23:16]);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
    endtask

    task automatic write_burst(input bus_addr_t addr, input int len, input logic abort);
        data_byte_t d;
        nibble_t    unused_q;
        int         idx;
        begin_txn();
        send_header(1'b0, addr);
        for (int i = 0; i < len; i++) begin
            d = data_byte_t'(rand_bits(8));
            send_byte(d);
            idx = (int'(addr) + i) % mem_depth;
            model_mem[idx]   = d;
            model_valid[idx] = 1'b1;
        end
        if (abort) begin
            qspi_cycle(nibble_t'(rand_bits(4)), 1'b0, unused_q);    // half a byte.
        end
        end_txn();
        burst_addr.push_back(addr);
        burst_len.push_back(len);
    endtask

    task automatic read_burst(input bus_addr_t addr, input int len);
        nibble_t hi;
        nibble_t lo;
        int      idx;
        begin_txn();
        send_header(1'b1, addr);
        for (int i = 0; i < 4; i++) begin
            qspi_cycle(nibble_t'(rand_bits(4)), 1'b0, hi);    // dummy clocks.
        end
        for (int i = 0; i < len; i++) begin
            qspi_cycle(4'h0, 1'b1, hi);
            qspi_cycle(4'h0, 1'b1, lo);
            idx = (int'(addr) + i) % mem_depth;
            if (!model_valid[idx]) begin
                $display("read burst covers location %0d that was never written", idx);
                $display("Checks failed");
                $fatal(1, "testbench read an unwritten location");
            end
            check_byte({hi, lo}, model_mem[idx], bus_addr_t'(int'(addr) + i));
        end
        end_txn();
    endtask

    initial begin
        #(timeout_ns);
        $display("simulation timed out after %0d transactions", txn_count);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        bus_addr_t addr;
        int        len;
        int        pick;
        int        base;
        int        run;
        lfsr_state = 32'h162995fa;
        txn_count  = 0;
        qspi_reset = 1'b1;
        qspi_clk   = 1'b1;    // idles high between transactions.
        qspi_ncs   = 1'b1;
        io_in      = '0;
        for (int i = 0; i < mem_depth; i++) begin
            model_valid[i] = 1'b0;
        end
        wait_clks(2);
        qspi_reset = 1'b0;
        check_oe(io_oe, 1'b0);
        wait_clks(half_qspi);

        repeat (4) begin
            addr = bus_addr_t'(rand_bits(24));
            len  = 1 + int'(rand_bits(3));
            write_burst(addr, len, 1'b0);
            read_burst(addr, len);
        end

        // bursts across the top of memory.
        addr = bus_addr_t'(rand_bits(24)) & ~bus_addr_t'(mem_depth - 1);
        addr = addr | bus_addr_t'(mem_depth - 3);
        write_burst(addr, 6, 1'b0);
        read_burst(addr, 6);
        read_burst(addr + 24'd1, 4);

        // ncs rises mid byte, the byte after the burst keeps its old value.
        addr = bus_addr_t'(rand_bits(24));
        len  = 1 + int'(rand_bits(2));
        write_burst(addr, len + 1, 1'b0);
        write_burst(addr, len, 1'b1);
        read_burst(addr, len + 1);

        repeat (60) begin
            if (rand_bits(1) == 32'd0 || burst_addr.size() == 0) begin
                addr = bus_addr_t'(rand_bits(24));
                len  = 1 + int'(rand_bits(3));
                write_burst(addr, len, 1'b0);
            end else begin
                pick = int'(rand_bits(8)) % burst_addr.size();
                read_burst(burst_addr[pick], burst_len[pick]);
            end
        end

        // every written location, in runs of up to 8.
        base = 0;
        while (base < mem_depth) begin
            if (!model_valid[base]) begin
                base++;
            end else begin
                run = 0;
                while (base + run < mem_depth && run < 8 && model_valid[base + run]) begin
                    run++;
                end
                read_burst(bus_addr_t'(base), run);
                base += run;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== logic/qspi_mem_top.sv ====
module qspi_mem_top import qspi_mem_pkg::*; #(
    parameter int mem_depth = 256
) (
    input  logic    clk,
    input  logic    qspi_reset,
    input  logic    qspi_clk,
    input  logic    qspi_ncs,
    input  nibble_t io_in,
    output nibble_t io_out,
    output logic    io_oe
);
    localparam int addr_w = $clog2(mem_depth);

    rx_byte_t          rx_byte;
    logic              rx_strobe;
    logic              start;
    logic              tx_req;
    data_byte_t        tx_byte;
    logic              mem_we;
    logic              mem_re;
    logic [addr_w-1:0] mem_addr;
    data_byte_t        mem_wdata;
    data_byte_t        mem_rdata;

    qspi_phy phy_i (
        .clk        (clk),
        .qspi_reset (qspi_reset),
        .qspi_clk   (qspi_clk),
        .qspi_ncs   (qspi_ncs),
        .io_in      (io_in),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .start      (start),
        .tx_req     (tx_req)
    );

    qspi_mem_ctrl #(
        .mem_depth (mem_depth)
    ) ctrl_i (
        .clk        (clk),
        .qspi_reset (qspi_reset),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .start      (start),
        .tx_req     (tx_req),
        .tx_byte    (tx_byte),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    byte_ram #(
        .mem_depth (mem_depth)
    ) ram_i (
        .clk   (clk),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== logic/qspi_mem_ctrl.sv ====
module qspi_mem_ctrl import qspi_mem_pkg::*; #(
    parameter int mem_depth = 256,
    localparam int addr_w = $clog2(mem_depth)
) (
    input  logic              clk,
    input  logic              qspi_reset,
    input  rx_byte_t          rx_byte,
    input  logic              rx_strobe,
    input  logic              start,
    input  logic              tx_req,
    output data_byte_t        tx_byte,
    output logic              mem_we,
    output logic              mem_re,
    output logic [addr_w-1:0] mem_addr,
    output data_byte_t        mem_wdata,
    input  data_byte_t        mem_rdata
);
    ctrl_state_e state;
    logic [1:0]  addr_bytes;    // address bytes seen so far.
    logic [15:0] addr_hi;
    bus_addr_t   next_addr;
    logic        read_cmd;
    logic        fetch_q;       // rdata valid this cycle.

    assign next_addr = {addr_hi, rx_byte.data};

    always_ff @(posedge clk or posedge qspi_reset) begin
        if (qspi_reset) begin
            state      <= CTRL_IDLE;
            addr_bytes <= 2'd0;
            read_cmd   <= 1'b0;
            mem_addr   <= '0;
            mem_we     <= 1'b0;
            mem_re     <= 1'b0;
            fetch_q    <= 1'b0;
        end else begin
            mem_we  <= 1'b0;
            mem_re  <= 1'b0;
            fetch_q <= mem_re;
            if (mem_we) begin
                mem_addr <= mem_addr + 1'b1;    // wraps at mem_depth.
            end
            if (start) begin
                state <= CTRL_IDLE;
            end else begin
                case (state)
                    CTRL_IDLE: begin
                        if (rx_strobe && rx_byte.is_cmd) begin
                            read_cmd   <= rx_byte.read_req;
                            addr_bytes <= 2'd0;
                            state      <= CTRL_ADDR;
                        end
                    end
                    CTRL_ADDR: begin
                        if (rx_strobe) begin
                            addr_bytes <= addr_bytes + 2'd1;
                            if (addr_bytes == 2'd2) begin
                                // only the low bits address the memory.
                                mem_addr <= next_addr[addr_w-1:0];
                                if (read_cmd) begin
                                    mem_re <= 1'b1;    // prefetch first byte.
                                    state  <= CTRL_READ;
                                end else begin
                                    state <= CTRL_WRITE;
                                end
                            end
                        end
                    end
                    CTRL_WRITE: begin
                        if (rx_strobe) begin
                            mem_we <= 1'b1;
                        end
                    end
                    CTRL_READ: begin
                        if (tx_req) begin
                            mem_addr <= mem_addr + 1'b1;
                            mem_re   <= 1'b1;
                        end
                    end
                    default: state <= CTRL_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == CTRL_ADDR && rx_strobe) begin
            addr_hi <= next_addr[15:0];
        end
        if (state == CTRL_WRITE && rx_strobe) begin
            mem_wdata <= rx_byte.data;
        end
        if (fetch_q) begin
            tx_byte <= mem_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (qspi_reset) !(mem_we && mem_re));

    // the phy only latches bytes once the read address is complete.
    assert property (@(posedge clk) disable iff (qspi_reset) tx_req |-> state == CTRL_READ);

endmodule

// ==== logic/qspi_phy.sv ====
module qspi_phy import qspi_mem_pkg::*; (
    input  logic       clk,
    input  logic       qspi_reset,
    input  logic       qspi_clk,
    input  logic       qspi_ncs,
    input  nibble_t    io_in,
    output nibble_t    io_out,
    output logic       io_oe,
    input  data_byte_t tx_byte,
    output rx_byte_t   rx_byte,
    output logic       rx_strobe,
    output logic       start,
    output logic       tx_req
);
    phy_phase_e phase;
    logic       phase_rst;
    logic [2:0] cnt;
    logic       read_cmd;
    nibble_t    upper_nibble;
    logic       rx_done;
    logic       rx_toggle;
    logic       tx_load;
    logic       tx_sw;
    logic       tx_toggle;
    data_byte_t tx_data;
    logic [2:0] ncs_sync;
    logic [2:0] rx_sync;
    logic [2:0] tx_sync;

    assign phase_rst = qspi_reset || qspi_ncs;    // idle while deselected.
    assign rx_done = cnt[0] && (phase == PHASE_CMD || phase == PHASE_RECEIVE);
    assign tx_load = (phase == PHASE_SEND) && !tx_sw;

    always_ff @(posedge qspi_clk or posedge phase_rst) begin
        if (phase_rst) begin
            phase    <= PHASE_CMD;
            cnt      <= 3'd0;
            read_cmd <= 1'b0;
        end else begin
            cnt <= cnt + 3'd1;
            case (phase)
                PHASE_CMD: begin
                    if (cnt == 3'd1) begin
                        read_cmd <= !io_in[0];    // bit 0 low means read.
                        phase    <= PHASE_RECEIVE;
                    end
                end
                PHASE_RECEIVE: begin
                    // last nibble of the third address byte.
                    if (read_cmd && cnt == 3'd7) begin
                        phase <= PHASE_DUMMY;
                    end
                end
                PHASE_DUMMY: begin
                    if (cnt == 3'd3) begin
                        phase <= PHASE_SEND;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge qspi_clk) begin
        if (!cnt[0]) begin
            upper_nibble <= io_in;    // high nibble first.
        end
        if (rx_done) begin
            rx_byte.data     <= {upper_nibble, io_in};
            rx_byte.is_cmd   <= (phase == PHASE_CMD);
            rx_byte.read_req <= !io_in[0];
        end
    end

    // toggles survive ncs going high, so the last byte still gets through.
    always_ff @(posedge qspi_clk or posedge qspi_reset) begin
        if (qspi_reset) begin
            rx_toggle <= 1'b0;
        end else if (rx_done) begin
            rx_toggle <= !rx_toggle;
        end
    end

    always_ff @(negedge qspi_clk or posedge phase_rst) begin
        if (phase_rst) begin
            tx_sw <= 1'b0;
        end else begin
            tx_sw <= tx_load;    // high nibble out for one clock.
        end
    end

    always_ff @(negedge qspi_clk) begin
        if (tx_load) begin
            tx_data <= tx_byte;
        end
    end

    always_ff @(negedge qspi_clk or posedge qspi_reset) begin
        if (qspi_reset) begin
            tx_toggle <= 1'b0;
        end else if (tx_load) begin
            tx_toggle <= !tx_toggle;
        end
    end

    assign io_oe = (phase == PHASE_SEND);
    assign io_out = tx_sw ? tx_data[7:4] : tx_data[3:0];

    always_ff @(posedge clk or posedge qspi_reset) begin
        if (qspi_reset) begin
            ncs_sync  <= 3'b111;
            rx_sync   <= 3'b000;
            tx_sync   <= 3'b000;
            start     <= 1'b0;
            rx_strobe <= 1'b0;
            tx_req    <= 1'b0;
        end else begin
            ncs_sync  <= {ncs_sync[1:0], qspi_ncs};
            rx_sync   <= {rx_sync[1:0], rx_toggle};
            tx_sync   <= {tx_sync[1:0], tx_toggle};
            start     <= ncs_sync[2] && !ncs_sync[1];    // falling ncs.
            rx_strobe <= rx_sync[2] ^ rx_sync[1];
            tx_req    <= tx_sync[2] ^ tx_sync[1];
        end
    end

    // receive and send never overlap within one transaction.
    assert property (@(posedge clk) disable iff (qspi_reset) !(rx_strobe && tx_req));

    assert property (@(posedge clk) disable iff (qspi_reset) io_oe |-> !qspi_ncs);

endmodule

// ==== logic/byte_ram.sv ====
module byte_ram import qspi_mem_pkg::*; #(
    parameter int mem_depth = 256,
    localparam int addr_w = $clog2(mem_depth)
) (
    input  logic              clk,
    input  logic              we,
    input  logic              re,
    input  logic [addr_w-1:0] addr,
    input  data_byte_t        wdata,
    output data_byte_t        rdata
);
    data_byte_t mem [mem_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (re) begin
            rdata <= mem[addr];    // one cycle latency.
        end
    end

endmodule

// ==== logic/qspi_mem_pkg.sv ====
package qspi_mem_pkg;

    typedef logic [7:0] data_byte_t;   // one byte on the bus or in memory.
    typedef logic [3:0] nibble_t;      // one transfer on the four data lines.
    typedef logic [23:0] bus_addr_t;   // address as the host sends it.

    // phases of a transaction, seen from the qspi clock domain.
    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_RECEIVE,
        PHASE_DUMMY,
        PHASE_SEND
    } phy_phase_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,    // waiting for the command byte.
        CTRL_ADDR,    // taking the three address bytes.
        CTRL_WRITE,
        CTRL_READ
    } ctrl_state_e;

    // byte handed from the phy to the control, 10 bits.
    typedef struct packed {
        data_byte_t data;
        logic       is_cmd;      // first byte of the transaction.
        logic       read_req;    // direction, only valid with is_cmd.
    } rx_byte_t;

endpackage
